// File: alu_pkg.sv
`default_nettype none

package alu_pkg;

  typedef logic [63:0] word_t;
  typedef logic [5:0]  flags_t;  // c o a s z p, high to low
  typedef logic [3:0]  op_t;
  typedef logic [1:0]  size_t;
  typedef logic [3:0]  cond_t;
  typedef logic [4:0]  carry_t;  // out of bits 3, 7, 15, 31, 63

  localparam op_t op_add  = 4'd0;
  localparam op_t op_sub  = 4'd1;
  localparam op_t op_and  = 4'd2;
  localparam op_t op_or   = 4'd3;
  localparam op_t op_xor  = 4'd4;
  localparam op_t op_mov  = 4'd5;
  localparam op_t op_zxt  = 4'd6;
  localparam op_t op_sxt  = 4'd7;
  localparam op_t op_cmov = 4'd8;
  localparam op_t op_cset = 4'd9;
  localparam op_t op_sahf = 4'd10;

  localparam size_t sz_8  = 2'd0;
  localparam size_t sz_16 = 2'd1;
  localparam size_t sz_32 = 2'd2;
  localparam size_t sz_64 = 2'd3;

  localparam cond_t cc_z   = 4'd0;
  localparam cond_t cc_nz  = 4'd1;
  localparam cond_t cc_s   = 4'd2;
  localparam cond_t cc_ns  = 4'd3;
  localparam cond_t cc_ugt = 4'd4;
  localparam cond_t cc_ule = 4'd5;
  localparam cond_t cc_uge = 4'd6;
  localparam cond_t cc_ult = 4'd7;
  localparam cond_t cc_sgt = 4'd8;
  localparam cond_t cc_sle = 4'd9;
  localparam cond_t cc_sge = 4'd10;
  localparam cond_t cc_slt = 4'd11;
  localparam cond_t cc_o   = 4'd12;
  localparam cond_t cc_no  = 4'd13;
  localparam cond_t cc_p   = 4'd14;
  localparam cond_t cc_np  = 4'd15;

  localparam int flg_c = 5;
  localparam int flg_o = 4;
  localparam int flg_a = 3;
  localparam int flg_s = 2;
  localparam int flg_z = 1;
  localparam int flg_p = 0;

  localparam int cy_aux = 0;
  localparam int cy_8   = 1;
  localparam int cy_16  = 2;
  localparam int cy_32  = 3;
  localparam int cy_64  = 4;

  // sign bit of a word at the given operand size
  function automatic logic msb_at(input word_t v, input size_t sz);
    case (sz)
      sz_8:    return v[7];
      sz_16:   return v[15];
      sz_32:   return v[31];
      default: return v[63];
    endcase
  endfunction

endpackage

`default_nettype wire

// File: alu_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alu_stage_if;
  import alu_pkg::*;

  word_t  result;   // already sized
  carry_t carries;  // raw, not yet turned into borrows
  op_t    op;
  size_t  size;
  logic   sign1;
  logic   sign2;    // of val2 before inversion

  modport exec (
    output result,
    output carries,
    output op,
    output size,
    output sign1,
    output sign2
  );

  modport stage (
    input result,
    input carries,
    input op,
    input size,
    input sign1,
    input sign2
  );

endinterface

`default_nettype wire

// File: cond_eval.sv
`timescale 1ns/1ps
`default_nettype none

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            taken
);
  import alu_pkg::*;

  logic c, o, s, z, p;
  logic lt;

  assign c  = flags[flg_c];
  assign o  = flags[flg_o];
  assign s  = flags[flg_s];
  assign z  = flags[flg_z];
  assign p  = flags[flg_p];
  assign lt = s ^ o;  // signed less-than

  always_comb begin
    case (cond)
      cc_z:    taken = z;
      cc_nz:   taken = ~z;
      cc_s:    taken = s;
      cc_ns:   taken = ~s;
      cc_ugt:  taken = ~(c | z);
      cc_ule:  taken = c | z;
      cc_uge:  taken = ~c;
      cc_ult:  taken = c;
      cc_sgt:  taken = ~(lt | z);
      cc_sle:  taken = lt | z;
      cc_sge:  taken = ~lt;
      cc_slt:  taken = lt;
      cc_o:    taken = o;
      cc_no:   taken = ~o;
      cc_p:    taken = p;
      default: taken = ~p;  // cc_np
    endcase
  end

endmodule

`default_nettype wire

// File: exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  alu_pkg::op_t    op,
  input  alu_pkg::size_t  size,
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::word_t  val1,
  input  alu_pkg::word_t  val2,
  input  alu_pkg::flags_t flags_in,
  alu_stage_if.exec       st
);
  import alu_pkg::*;

  logic        is_sub;
  word_t       addend;
  logic [4:0]  s0;
  logic [4:0]  s1;
  logic [8:0]  s2;
  logic [16:0] s3;
  logic [32:0] s4;
  word_t       sum;
  carry_t      carries;

  logic        taken;
  word_t       pre;
  word_t       sized;
  word_t       zext;
  word_t       sext;
  word_t       res;

  cond_eval cond_i (
    .flags (flags_in),
    .cond  (cond),
    .taken (taken)
  );

  // adder split at the points where carries are tapped
  assign is_sub = (op == op_sub);
  assign addend = is_sub ? ~val2 : val2;

  assign s0 = {1'b0, val1[3:0]} + {1'b0, addend[3:0]} + {4'b0, is_sub};
  assign s1 = {1'b0, val1[7:4]} + {1'b0, addend[7:4]} + {4'b0, s0[4]};
  assign s2 = {1'b0, val1[15:8]} + {1'b0, addend[15:8]} + {8'b0, s1[4]};
  assign s3 = {1'b0, val1[31:16]} + {1'b0, addend[31:16]} + {16'b0, s2[8]};
  assign s4 = {1'b0, val1[63:32]} + {1'b0, addend[63:32]} + {32'b0, s3[16]};

  assign sum = {s4[31:0], s3[15:0], s2[7:0], s1[3:0], s0[3:0]};

  always_comb begin
    carries         = '0;
    carries[cy_aux] = s0[4];
    carries[cy_8]   = s1[4];
    carries[cy_16]  = s2[8];
    carries[cy_32]  = s3[16];
    carries[cy_64]  = s4[32];
  end

  // value before sizing
  always_comb begin
    case (op)
      op_add, op_sub: pre = sum;
      op_and:         pre = val1 & val2;
      op_or:          pre = val1 | val2;
      op_xor:         pre = val1 ^ val2;
      op_mov:         pre = val2;
      op_cmov:        pre = taken ? val2 : val1;
      default:        pre = '0;
    endcase
  end

  always_comb begin
    case (size)
      sz_8:    sized = {val1[63:8], pre[7:0]};    // upper bits of val1 kept
      sz_16:   sized = {val1[63:16], pre[15:0]};
      sz_32:   sized = {32'b0, pre[31:0]};        // 32-bit write clears the top
      default: sized = pre;
    endcase
  end

  always_comb begin
    case (size)
      sz_8:    zext = {56'b0, val2[7:0]};
      sz_16:   zext = {48'b0, val2[15:0]};
      sz_32:   zext = {32'b0, val2[31:0]};
      default: zext = val2;
    endcase
  end

  always_comb begin
    case (size)
      sz_8:    sext = {{56{val2[7]}}, val2[7:0]};
      sz_16:   sext = {{48{val2[15]}}, val2[15:0]};
      sz_32:   sext = {{32{val2[31]}}, val2[31:0]};
      default: sext = val2;
    endcase
  end

  always_comb begin
    case (op)
      op_zxt:  res = zext;
      op_sxt:  res = sext;
      op_cset: res = {63'b0, taken};
      op_sahf: res = {58'b0, flags_in};
      default: res = sized;
    endcase
  end

  assign st.result  = res;
  assign st.carries = carries;
  assign st.op      = op;
  assign st.size    = size;
  assign st.sign1   = msb_at(val1, size);
  assign st.sign2   = msb_at(val2, size);

endmodule

`default_nettype wire

// File: flag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module flag_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            data_en,
  alu_stage_if.stage      st,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags_out,
  output logic            flags_we,
  output logic            ret_en
);
  import alu_pkg::*;

  logic   data_en_q;
  op_t    op_q;
  word_t  result_q;
  carry_t carries_q;
  size_t  size_q;
  logic   sign1_q;
  logic   sign2_q;

  logic   is_sub;
  logic   is_arith;
  logic   is_logic;
  logic   cy_sized;
  logic   res_sign;
  logic   res_zero;
  logic   ovf;
  flags_t flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_en_q <= 1'b0;
      op_q      <= op_add;
      result_q  <= '0;
    end else begin
      data_en_q <= data_en;
      op_q      <= st.op;
      result_q  <= st.result;
    end
  end

  always_ff @(posedge clk) begin
    carries_q <= st.carries;
    size_q    <= st.size;
    sign1_q   <= st.sign1;
    sign2_q   <= st.sign2;
  end

  assign is_sub   = (op_q == op_sub);
  assign is_arith = (op_q == op_add) || is_sub;
  assign is_logic = (op_q == op_and) || (op_q == op_or) || (op_q == op_xor);

  // carry and zero picked at the operand size
  always_comb begin
    case (size_q)
      sz_8: begin
        cy_sized = carries_q[cy_8];
        res_zero = (result_q[7:0] == 8'b0);
      end
      sz_16: begin
        cy_sized = carries_q[cy_16];
        res_zero = (result_q[15:0] == 16'b0);
      end
      sz_32: begin
        cy_sized = carries_q[cy_32];
        res_zero = (result_q[31:0] == 32'b0);
      end
      default: begin
        cy_sized = carries_q[cy_64];
        res_zero = (result_q == '0);
      end
    endcase
  end

  assign res_sign = msb_at(result_q, size_q);

  // sign2 is the un-inverted operand, so sub flips the sign test
  assign ovf = is_sub ? (sign1_q ^ sign2_q) & (res_sign ^ sign1_q)
                      : ~(sign1_q ^ sign2_q) & (res_sign ^ sign1_q);

  always_comb begin
    flags        = '0;
    flags[flg_c] = is_arith & (cy_sized ^ is_sub);  // borrow on sub
    flags[flg_o] = is_arith & ovf;
    flags[flg_a] = is_arith & (carries_q[cy_aux] ^ is_sub);
    flags[flg_s] = res_sign;
    flags[flg_z] = res_zero;
    flags[flg_p] = ~^result_q[7:0];  // even parity of low byte
  end

  assign ret_en    = data_en_q;
  assign flags_we  = data_en_q & (is_arith | is_logic);
  assign flags_out = flags_we ? flags : '0;
  assign result    = result_q;

endmodule

`default_nettype wire

// File: alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
  input  logic            clk,
  input  logic            rst,
  input  logic            data_en,
  input  alu_pkg::op_t    op,
  input  alu_pkg::size_t  size,
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::word_t  val1,
  input  alu_pkg::word_t  val2,
  input  alu_pkg::flags_t flags_in,
  output alu_pkg::word_t  result,
  output alu_pkg::flags_t flags_out,
  output logic            flags_we,
  output logic            ret_en
);

  alu_stage_if st_if ();

  // combinational execute
  exec_unit exec_i (
    .op       (op),
    .size     (size),
    .cond     (cond),
    .val1     (val1),
    .val2     (val2),
    .flags_in (flags_in),
    .st       (st_if.exec)
  );

  // one register stage, flags formed after it
  flag_stage stage_i (
    .clk       (clk),
    .rst       (rst),
    .data_en   (data_en),
    .st        (st_if.stage),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we),
    .ret_en    (ret_en)
  );

endmodule

`default_nettype wire

// File: alu_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core_checker (
  input logic            clk,
  input logic            rst,
  input logic            data_en,
  input logic            ret_en,
  input logic            flags_we,
  input alu_pkg::flags_t flags_out
);

  // first cycle out of reset returns nothing
  ret_after_rst: assert property (@(posedge clk) rst |=> !ret_en)
    else $error("ret_en high in the cycle after reset");

  ret_follows_en: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |-> (ret_en == $past(data_en))
  ) else $error("ret_en does not follow data_en by one cycle");

  we_needs_ret: assert property (@(posedge clk) disable iff (rst) flags_we |-> ret_en)
    else $error("flags_we high without ret_en");

  flags_quiet: assert property (
    @(posedge clk) disable iff (rst)
    !flags_we |-> (flags_out == '0)
  ) else $error("flags_out nonzero while flags_we is low");

endmodule

`default_nettype wire

// File: tb_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_core;
  import alu_pkg::*;

  logic   clk;
  logic   rst;
  logic   data_en;
  op_t    op;
  size_t  size;
  cond_t  cond;
  word_t  val1;
  word_t  val2;
  flags_t flags_in;
  word_t  result;
  flags_t flags_out;
  logic   flags_we;
  logic   ret_en;

  // golden vectors
  op_t    q_op[$];
  size_t  q_size[$];
  cond_t  q_cond[$];
  word_t  q_val1[$];
  word_t  q_val2[$];
  flags_t q_fin[$];
  word_t  q_res[$];
  flags_t q_flags[$];
  logic   q_we[$];

  int          value_errors;
  int          timeout_errors;
  logic [31:0] seed;

  alu_core alu_core_i (
    .clk       (clk),
    .rst       (rst),
    .data_en   (data_en),
    .op        (op),
    .size      (size),
    .cond      (cond),
    .val1      (val1),
    .val2      (val2),
    .flags_in  (flags_in),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we),
    .ret_en    (ret_en)
  );

  bind alu_core alu_core_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .data_en   (data_en),
    .ret_en    (ret_en),
    .flags_we  (flags_we),
    .flags_out (flags_out)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_value(input string name, input word_t exp, input word_t act);
    assert (exp === act)
      else begin
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        value_errors++;
      end
  endtask

  task automatic load_vectors();
    int     fd;
    int     n;
    string  line;
    logic [63:0] f[9];
    fd = $fopen("alu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open alu_golden.txt");
      timeout_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (n != 9) continue;
      q_op.push_back(f[0][3:0]);
      q_size.push_back(f[1][1:0]);
      q_cond.push_back(f[2][3:0]);
      q_val1.push_back(f[3]);
      q_val2.push_back(f[4]);
      q_fin.push_back(f[5][5:0]);
      q_res.push_back(f[6]);
      q_flags.push_back(f[7][5:0]);
      q_we.push_back(f[8][0]);
    end
    $fclose(fd);
  endtask

  initial begin
    int   gaps;
    int   waited;
    logic stop;
    clk            = 1'b0;
    rst            = 1'b1;
    data_en        = 1'b0;
    op             = '0;
    size           = '0;
    cond           = '0;
    val1           = '0;
    val2           = '0;
    flags_in       = '0;
    value_errors   = 0;
    timeout_errors = 0;
    seed           = 32'hb793_2780;
    stop           = 1'b0;

    load_vectors();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    compare_value("reset result", '0, result);
    compare_value("reset flags_out", '0, flags_out);
    compare_value("reset flags_we", '0, flags_we);
    compare_value("reset ret_en", '0, ret_en);

    for (int i = 0; i < q_op.size() && !stop; i++) begin
      seed = lcg_next(seed);
      gaps = seed[17:16];
      for (int g = 0; g < gaps; g++) begin
        data_en = 1'b0;
        @(posedge clk);
        #1;
        compare_value($sformatf("idle ret_en before vec%0d", i), '0, ret_en);
      end
      data_en  = 1'b1;
      op       = q_op[i];
      size     = q_size[i];
      cond     = q_cond[i];
      val1     = q_val1[i];
      val2     = q_val2[i];
      flags_in = q_fin[i];
      @(posedge clk);
      #1;
      waited = 0;
      while (!ret_en && waited < 10) begin
        data_en = 1'b0;  // no extra pulses while waiting
        @(posedge clk);
        #1;
        waited++;
      end
      assert (ret_en)
        else begin
          $display("timed out waiting for ret_en on vector %0d", i);
          timeout_errors++;
          stop = 1'b1;
        end
      if (!stop) begin
        compare_value($sformatf("vec%0d result", i), q_res[i], result);
        compare_value($sformatf("vec%0d flags", i), q_flags[i], flags_out);
        compare_value($sformatf("vec%0d flags_we", i), q_we[i], flags_we);
        compare_value($sformatf("vec%0d latency", i), 0, waited);
      end
    end

    data_en = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    compare_value("final idle ret_en", '0, ret_en);
    if (q_op.size() == 0) begin
      $display("no vectors were loaded");
      timeout_errors++;
    end

    $display("errors: %0d value, %0d timeout or setup", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: alu_golden.txt
# op size cond val1 val2 flags_in exp_result exp_flags exp_flags_we (all hex)
# flags are c o a s z p from high to low bit
0 3 0 ffffffffffffffff 0000000000000001 00 0000000000000000 2b 1
0 2 0 123456787fffffff 0000000000000001 00 0000000080000000 1d 1
0 1 0 aaaabbbbcccc8000 0000000000008000 00 aaaabbbbcccc0000 33 1
0 0 0 1111111111111108 0000000000000008 00 1111111111111110 08 1
1 3 0 0000000000000000 0000000000000001 00 ffffffffffffffff 2d 1
1 2 0 0000000080000000 0000000000000001 00 000000007fffffff 19 1
1 1 0 ffff000000000005 0000000000000005 00 ffff000000000000 03 1
1 0 0 0000000000000010 0000000000000020 00 00000000000000f0 25 1
1 0 0 0000000000000080 0000000000000001 00 000000000000007f 18 1
2 3 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 00 0f000f000f000f00 01 1
3 2 0 deadbeef00000080 0000000000000001 00 0000000000000081 01 1
4 1 0 123456789abcffff 000000000000ffff 00 123456789abc0000 03 1
4 0 0 55555555555555aa 000000000000002a 00 5555555555555580 04 1
5 0 0 1111111111111111 00000000000000ab 00 11111111111111ab 00 0
5 2 0 ffffffffffffffff aaaaaaaa12345678 00 0000000012345678 00 0
5 3 0 0000000000000000 0123456789abcdef 00 0123456789abcdef 00 0
6 1 0 0000000000000000 ffffffffffff8001 00 0000000000008001 00 0
7 0 0 0000000000000000 0000000000000080 00 ffffffffffffff80 00 0
7 1 0 0000000000000000 0000000000009000 00 ffffffffffff9000 00 0
7 2 0 0000000000000000 0000000070000000 00 0000000070000000 00 0
8 2 0 1111111111111111 2222222222222222 00 0000000011111111 00 0
8 0 1 aaaaaaaaaaaaaaaa 00000000000000bb 00 aaaaaaaaaaaaaabb 00 0
8 3 2 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 3 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 4 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 5 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 6 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 7 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 8 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 9 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 a 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 b 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 c 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 d 1111111111111111 2222222222222222 00 2222222222222222 00 0
8 3 e 1111111111111111 2222222222222222 00 1111111111111111 00 0
8 3 f 1111111111111111 2222222222222222 00 2222222222222222 00 0
9 3 0 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 1 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 2 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 3 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 4 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 5 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 6 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 7 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 8 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 9 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 c 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 d 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 e 0000000000000000 0000000000000000 3f 0000000000000001 00 0
9 3 f 0000000000000000 0000000000000000 3f 0000000000000000 00 0
9 3 a 0000000000000000 0000000000000000 04 0000000000000000 00 0
9 3 b 0000000000000000 0000000000000000 04 0000000000000001 00 0
a 3 0 0000000000000000 0000000000000000 2d 000000000000002d 00 0
a 3 0 ffffffffffffffff 0000000000000000 3f 000000000000003f 00 0

// File: verilog.f
alu_pkg.sv
alu_stage_if.sv
cond_eval.sv
exec_unit.sv
flag_stage.sv
alu_core.sv
alu_core_checker.sv
tb_alu_core.sv
